//--- design/oldland_isa_pkg.sv
package oldland_isa_pkg;

	localparam int class_w = 2;
	localparam int opcode_w = 5;
	localparam int reg_idx_w = 4;
	localparam int cond_w = 3;
	localparam int imm12_w = 12;
	localparam int imm14_w = 14;

	typedef enum logic [class_w-1:0] {
		class_alu = 2'b00,
		class_branch = 2'b01,
		class_mem = 2'b10,
		class_misc = 2'b11
	} instr_class_t;

	typedef logic [reg_idx_w-1:0] reg_idx_t;

	// branch class opcodes.
	localparam logic [opcode_w-1:0] op_branch = 5'd0;
	localparam logic [opcode_w-1:0] op_call = 5'd1;
	localparam logic [opcode_w-1:0] op_swi = 5'd2;
	localparam logic [opcode_w-1:0] op_rfe = 5'd3;

	// misc class opcodes, the control register index sits in the cond field.
	localparam logic [opcode_w-1:0] op_rdcr = 5'd0;
	localparam logic [opcode_w-1:0] op_wrcr = 5'd1;

	// memory opcodes carry the width in bits 1:0 and the store flag here.
	localparam int mem_store_bit = 2;

	typedef struct packed {
		instr_class_t iclass;
		logic [opcode_w-1:0] opcode;
		reg_idx_t rd;
		reg_idx_t ra;
		reg_idx_t rb;
		logic imm_sel;
		logic [imm12_w-1:0] imm12;
	} reg_fmt_t;

	typedef struct packed {
		instr_class_t iclass;
		logic [opcode_w-1:0] opcode;
		reg_idx_t rd;
		reg_idx_t ra;
		logic [cond_w-1:0] cond;
		logic [imm14_w-1:0] imm14;
	} imm_fmt_t;

	typedef union packed {
		reg_fmt_t reg_fmt;
		imm_fmt_t imm_fmt;
	} oldland_instr_t;

endpackage

//--- design/oldland_arch_pkg.sv
package oldland_arch_pkg;

	typedef enum logic [4:0] {
		alu_add = 5'h00,
		alu_addc = 5'h01,
		alu_sub = 5'h02,
		alu_subc = 5'h03,
		alu_lsl = 5'h04,
		alu_lsr = 5'h05,
		alu_and = 5'h06,
		alu_xor = 5'h07,
		alu_bic = 5'h08,
		alu_bst = 5'h09,
		alu_or = 5'h0a,
		alu_mov = 5'h0b,
		alu_cmp = 5'h0c,
		alu_orlo = 5'h0d,
		alu_asr = 5'h0e,
		alu_cpy = 5'h0f,
		alu_rdcr = 5'h10,
		alu_swivec = 5'h11,
		alu_rdfar = 5'h12
	} alu_op_t;

	// code 0 is never taken.
	typedef enum logic [2:0] {
		cond_ne = 3'd1,
		cond_eq = 3'd2,
		cond_nc = 3'd3,
		cond_c = 3'd4,
		cond_gt = 3'd5,
		cond_lt = 3'd6,
		cond_always = 3'd7
	} branch_cond_t;

	typedef enum logic [2:0] {
		cr_vector = 3'd0,
		cr_psr = 3'd1,
		cr_saved_psr = 3'd2,
		cr_far = 3'd3,
		cr_dfar = 3'd4
	} cr_idx_t;

	typedef enum logic [1:0] {
		width_byte = 2'b00,
		width_half = 2'b01,
		width_word = 2'b10
	} mem_width_t;

endpackage

//--- design/oldland_regfile.sv
`timescale 1ns/1ps

module oldland_regfile
	import oldland_isa_pkg::*;
#(
	parameter int data_width = 32
) (
	input logic clk,
	input logic rst,
	input reg_idx_t ra_sel,
	input reg_idx_t rb_sel,
	input logic wr_en,
	input reg_idx_t wr_sel,
	input logic [data_width-1:0] wr_data,
	output logic [data_width-1:0] ra_data,
	output logic [data_width-1:0] rb_data
);

	localparam int num_regs = 2 ** reg_idx_w;

	logic [data_width-1:0] regs [num_regs];

	assign ra_data = regs[ra_sel];
	assign rb_data = regs[rb_sel];

	// r0 is an ordinary register here.
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < num_regs; i++)
				regs[i] <= '0;
		end else if (wr_en) begin
			regs[wr_sel] <= wr_data;
		end
	end

endmodule

//--- design/oldland_decode.sv
`timescale 1ns/1ps

module oldland_decode
	import oldland_isa_pkg::*;
	import oldland_arch_pkg::*;
(
	input logic clk,
	input logic rst,
	input oldland_instr_t instr,
	input logic instr_valid,
	input logic [31:0] pc_plus_4,
	input logic [31:0] rf_ra_data,
	input logic [31:0] rf_rb_data,
	output reg_idx_t rf_ra_sel,
	output reg_idx_t rf_rb_sel,
	output logic [31:0] ra,
	output logic [31:0] rb,
	output logic [31:0] imm32,
	output logic [31:0] pc_plus_4_out,
	output reg_idx_t rd_sel,
	output logic update_rd,
	output alu_op_t alu_opc,
	output logic alu_op1_ra,
	output logic alu_op1_rb,
	output logic alu_op2_rb,
	output logic mem_load,
	output logic mem_store,
	output mem_width_t mem_width,
	output branch_cond_t branch_condition,
	output instr_class_t instr_class,
	output logic is_call,
	output logic update_flags,
	output cr_idx_t cr_sel,
	output logic write_cr,
	output logic is_swi,
	output logic is_rfe
);

	instr_class_t cls;
	alu_op_t alu_field;
	alu_op_t next_opc;
	logic [31:0] imm12_ext;
	logic [31:0] imm14_ext;
	logic op_is_call, op_is_swi, op_is_rfe;
	logic op_is_rdcr, op_is_wrcr, op_is_store, op_is_cmp;

	assign cls = instr.reg_fmt.iclass;
	assign alu_field = alu_op_t'(instr.reg_fmt.opcode);

	assign imm12_ext = {{(32-imm12_w){instr.reg_fmt.imm12[imm12_w-1]}}, instr.reg_fmt.imm12};
	assign imm14_ext = {{(32-imm14_w){instr.imm_fmt.imm14[imm14_w-1]}}, instr.imm_fmt.imm14};

	assign op_is_call = cls == class_branch && instr.imm_fmt.opcode == op_call;
	assign op_is_swi = cls == class_branch && instr.imm_fmt.opcode == op_swi;
	assign op_is_rfe = cls == class_branch && instr.imm_fmt.opcode == op_rfe;
	assign op_is_rdcr = cls == class_misc && instr.imm_fmt.opcode == op_rdcr;
	assign op_is_wrcr = cls == class_misc && instr.imm_fmt.opcode == op_wrcr;
	assign op_is_store = cls == class_mem && instr.imm_fmt.opcode[mem_store_bit];
	assign op_is_cmp = cls == class_alu && alu_field == alu_cmp;

	// stores take their data register from the rd field.
	assign rf_ra_sel = instr.reg_fmt.ra;
	assign rf_rb_sel = cls == class_mem ? instr.imm_fmt.rd : instr.reg_fmt.rb;

	always_comb begin
		case (cls)
		class_alu: next_opc = alu_field;
		class_branch: begin
			if (op_is_swi)
				next_opc = alu_swivec;
			else if (op_is_rfe)
				next_opc = alu_rdfar;
			else
				next_opc = alu_add;
		end
		class_misc: next_opc = alu_rdcr;
		default: next_opc = alu_add;
		endcase
	end

	always_ff @(posedge clk) begin
		ra <= rf_ra_data;
		rb <= rf_rb_data;
		pc_plus_4_out <= pc_plus_4;
		imm32 <= cls == class_alu ? imm12_ext : imm14_ext;
		rd_sel <= instr.reg_fmt.rd;
		alu_opc <= next_opc;
		alu_op1_ra <= cls == class_mem || (cls == class_alu && alu_field != alu_cpy);
		alu_op1_rb <= cls == class_alu && alu_field == alu_cpy;
		alu_op2_rb <= cls == class_alu && !instr.reg_fmt.imm_sel;
		mem_width <= mem_width_t'(instr.imm_fmt.opcode[1:0]);
		branch_condition <= branch_cond_t'(instr.imm_fmt.cond);
		cr_sel <= cr_idx_t'(instr.imm_fmt.cond);
	end

	// an empty slot leaves every enable low.
	always_ff @(posedge clk) begin
		if (rst || !instr_valid) begin
			instr_class <= class_alu;
			update_rd <= 1'b0;
			update_flags <= 1'b0;
			mem_load <= 1'b0;
			mem_store <= 1'b0;
			is_call <= 1'b0;
			is_swi <= 1'b0;
			is_rfe <= 1'b0;
			write_cr <= 1'b0;
		end else begin
			instr_class <= cls;
			update_rd <= (cls == class_alu && !op_is_cmp) || op_is_call || op_is_rdcr;
			update_flags <= op_is_cmp;
			mem_load <= cls == class_mem && !op_is_store;
			mem_store <= op_is_store;
			is_call <= op_is_call;
			is_swi <= op_is_swi;
			is_rfe <= op_is_rfe;
			write_cr <= op_is_wrcr;
		end
	end

endmodule

//--- design/oldland_exec.sv
`timescale 1ns/1ps

module oldland_exec
	import oldland_isa_pkg::*;
	import oldland_arch_pkg::*;
#(
	parameter int data_width = 32,
	parameter int vector_align = 6
) (
	input logic clk,
	input logic rst,
	input logic [data_width-1:0] ra,
	input logic [data_width-1:0] rb,
	input logic [data_width-1:0] imm32,
	input logic [data_width-1:0] pc_plus_4,
	input reg_idx_t rd_sel,
	input logic update_rd,
	input alu_op_t alu_opc,
	input logic alu_op1_ra,
	input logic alu_op1_rb,
	input logic alu_op2_rb,
	input logic mem_load,
	input logic mem_store,
	input mem_width_t mem_width,
	input branch_cond_t branch_condition,
	input instr_class_t instr_class,
	input logic is_call,
	input logic update_flags,
	input cr_idx_t cr_sel,
	input logic write_cr,
	output logic branch_taken,
	output logic [data_width-1:0] alu_out,
	output logic mem_load_out,
	output logic mem_store_out,
	output mem_width_t mem_width_out,
	output logic [data_width-1:0] wr_val,
	output logic wr_result,
	output reg_idx_t rd_sel_out,
	output logic stall_clear,
	output logic [data_width-1:0] mar,
	output logic [data_width-1:0] mdr,
	output logic mem_wr_en,
	input logic is_swi,
	input logic is_rfe,
	output logic [data_width-vector_align-1:0] vector_base,
	output logic [data_width-1:0] pc_plus_4_out,
	input logic data_abort
);

	localparam int msb = data_width - 1;
	localparam int shamt_w = $clog2(data_width);
	localparam logic [vector_align-1:0] swi_offset = vector_align'(8);
	localparam logic [data_width-1:0] one = {{(data_width-1){1'b0}}, 1'b1};
	localparam logic [data_width-1:0] lo_mask = {{(data_width-16){1'b0}}, 16'hffff};

	logic [data_width-1:0] op1, op2, alu_q, carry_in, cr_rd_val;
	logic [shamt_w-1:0] shamt;
	logic alu_c, alu_z, alu_n, alu_o;
	logic cond_met;
	logic c_flag, z_flag, n_flag, o_flag;
	logic [3:0] psr;
	logic [3:0] saved_psr;
	logic [data_width-vector_align-1:0] vector_addr;
	logic [data_width-1:0] fault_address;
	logic [data_width-1:0] data_fault_address;

	assign op1 = alu_op1_ra ? ra : alu_op1_rb ? rb : pc_plus_4;
	assign op2 = alu_op2_rb ? rb : imm32;
	assign shamt = op2[shamt_w-1:0];
	assign carry_in = {{(data_width-1){1'b0}}, c_flag};

	assign psr = {n_flag, o_flag, c_flag, z_flag};
	assign vector_base = vector_addr;

	// flag sources only matter for cmp, which is the one op that sets flags.
	assign alu_z = op1 == op2;
	assign alu_n = alu_q[msb];
	assign alu_o = (op1[msb] ^ op2[msb]) && (alu_q[msb] == op2[msb]);

	always_comb begin
		case (cr_sel)
		cr_vector: cr_rd_val = {vector_addr, {vector_align{1'b0}}};
		cr_psr: cr_rd_val = {{(data_width-4){1'b0}}, psr};
		cr_saved_psr: cr_rd_val = {{(data_width-4){1'b0}}, saved_psr};
		cr_far: cr_rd_val = fault_address;
		cr_dfar: cr_rd_val = data_fault_address;
		default: cr_rd_val = '0;
		endcase
	end

	always_comb begin
		alu_c = 1'b0;
		alu_q = '0;
		case (alu_opc)
		alu_add: {alu_c, alu_q} = op1 + op2;
		alu_addc: {alu_c, alu_q} = op1 + op2 + carry_in;
		alu_sub: {alu_c, alu_q} = op1 - op2;
		alu_subc: {alu_c, alu_q} = op1 - op2 - carry_in;
		alu_lsl: {alu_c, alu_q} = {1'b0, op1} << shamt;
		alu_lsr: alu_q = op1 >> shamt;
		alu_and: alu_q = op1 & op2;
		alu_xor: alu_q = op1 ^ op2;
		alu_bic: alu_q = op1 & ~(one << shamt);
		alu_bst: alu_q = op1 | (one << shamt);
		alu_or: alu_q = op1 | op2;
		alu_mov: alu_q = op2;
		alu_cmp: {alu_c, alu_q} = op1 - op2;
		alu_orlo: alu_q = op1 | (op2 & lo_mask);
		alu_asr: alu_q = $signed(op1) >>> shamt;
		alu_cpy: alu_q = op1;
		alu_rdcr: alu_q = cr_rd_val;
		alu_swivec: alu_q = {vector_addr, swi_offset};
		alu_rdfar: alu_q = fault_address;
		default: alu_q = '0;
		endcase
	end

	always_comb begin
		case (branch_condition)
		cond_always: cond_met = 1'b1;
		cond_ne: cond_met = !z_flag;
		cond_eq: cond_met = z_flag;
		cond_nc: cond_met = !c_flag;
		cond_c: cond_met = c_flag;
		cond_gt: cond_met = !z_flag && (n_flag == o_flag);
		cond_lt: cond_met = n_flag != o_flag;
		default: cond_met = 1'b0;
		endcase
	end

	// later writes win, so an explicit PSR write overrides rfe and cmp.
	always_ff @(posedge clk) begin
		if (rst) begin
			{n_flag, o_flag, c_flag, z_flag} <= 4'b0;
		end else begin
			if (update_flags)
				{n_flag, o_flag, c_flag, z_flag} <= {alu_n, alu_o, alu_c, alu_z};
			if (is_rfe)
				{n_flag, o_flag, c_flag, z_flag} <= saved_psr;
			if (write_cr && cr_sel == cr_psr)
				{n_flag, o_flag, c_flag, z_flag} <= ra[3:0];
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			vector_addr <= '0;
			saved_psr <= '0;
			fault_address <= '0;
			data_fault_address <= '0;
		end else begin
			if (write_cr && cr_sel == cr_vector)
				vector_addr <= ra[msb:vector_align];

			if (is_swi)
				saved_psr <= psr;
			else if (write_cr && cr_sel == cr_saved_psr)
				saved_psr <= ra[3:0];

			if (is_swi || data_abort)
				fault_address <= pc_plus_4;
			else if (write_cr && cr_sel == cr_far)
				fault_address <= ra;

			// mar still holds the address of the access that faulted.
			if (data_abort)
				data_fault_address <= mar;
			else if (write_cr && cr_sel == cr_dfar)
				data_fault_address <= ra;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			branch_taken <= 1'b0;
			stall_clear <= 1'b0;
			wr_result <= 1'b0;
			mem_load_out <= 1'b0;
			mem_store_out <= 1'b0;
			mem_wr_en <= 1'b0;
		end else begin
			branch_taken <= instr_class == class_branch && (cond_met || is_swi || is_rfe);
			stall_clear <= instr_class == class_branch;
			wr_result <= update_rd;
			mem_load_out <= mem_load;
			mem_store_out <= mem_store;
			mem_wr_en <= mem_store;
		end
	end

	always_ff @(posedge clk) begin
		alu_out <= alu_q;
		rd_sel_out <= rd_sel;
		pc_plus_4_out <= pc_plus_4;
		wr_val <= is_call ? pc_plus_4 : mem_store ? rb : alu_q;
		if (mem_load || mem_store) begin
			mar <= alu_q;
			mem_width_out <= mem_width;
		end
		if (mem_store)
			mdr <= rb;
	end

endmodule

//--- design/oldland_exec_top.sv
`timescale 1ns/1ps

module oldland_exec_top
	import oldland_isa_pkg::*;
	import oldland_arch_pkg::*;
#(
	parameter int data_width = 32,
	parameter int vector_align = 6
) (
	input logic clk,
	input logic rst,
	input oldland_instr_t instr,
	input logic instr_valid,
	input logic [31:0] pc_plus_4,
	input logic data_abort,
	output logic [data_width-1:0] alu_out,
	output logic branch_taken,
	output logic stall_clear,
	output logic wr_result,
	output reg_idx_t rd_sel_out,
	output logic [data_width-1:0] wr_val,
	output logic [data_width-1:0] mar,
	output logic [data_width-1:0] mdr,
	output logic mem_wr_en,
	output logic mem_load_out,
	output logic mem_store_out,
	output mem_width_t mem_width_out,
	output logic [data_width-vector_align-1:0] vector_base
);

	reg_idx_t rf_ra_sel, rf_rb_sel;
	logic [data_width-1:0] rf_ra_data, rf_rb_data;
	logic [data_width-1:0] ra, rb, imm32, dec_pc_plus_4;
	reg_idx_t rd_sel;
	logic update_rd, alu_op1_ra, alu_op1_rb, alu_op2_rb;
	logic mem_load, mem_store, is_call, update_flags;
	logic write_cr, is_swi, is_rfe;
	alu_op_t alu_opc;
	mem_width_t mem_width;
	branch_cond_t branch_condition;
	instr_class_t instr_class;
	cr_idx_t cr_sel;

	oldland_decode i_oldland_decode (
		.clk (clk),
		.rst (rst),
		.instr (instr),
		.instr_valid (instr_valid),
		.pc_plus_4 (pc_plus_4),
		.rf_ra_data (rf_ra_data),
		.rf_rb_data (rf_rb_data),
		.rf_ra_sel (rf_ra_sel),
		.rf_rb_sel (rf_rb_sel),
		.ra (ra),
		.rb (rb),
		.imm32 (imm32),
		.pc_plus_4_out (dec_pc_plus_4),
		.rd_sel (rd_sel),
		.update_rd (update_rd),
		.alu_opc (alu_opc),
		.alu_op1_ra (alu_op1_ra),
		.alu_op1_rb (alu_op1_rb),
		.alu_op2_rb (alu_op2_rb),
		.mem_load (mem_load),
		.mem_store (mem_store),
		.mem_width (mem_width),
		.branch_condition (branch_condition),
		.instr_class (instr_class),
		.is_call (is_call),
		.update_flags (update_flags),
		.cr_sel (cr_sel),
		.write_cr (write_cr),
		.is_swi (is_swi),
		.is_rfe (is_rfe)
	);

	oldland_regfile #(
		.data_width (data_width)
	) i_oldland_regfile (
		.clk (clk),
		.rst (rst),
		.ra_sel (rf_ra_sel),
		.rb_sel (rf_rb_sel),
		.wr_en (wr_result),
		.wr_sel (rd_sel_out),
		.wr_data (wr_val),
		.ra_data (rf_ra_data),
		.rb_data (rf_rb_data)
	);

	oldland_exec #(
		.data_width (data_width),
		.vector_align (vector_align)
	) i_oldland_exec (
		.clk (clk),
		.rst (rst),
		.ra (ra),
		.rb (rb),
		.imm32 (imm32),
		.pc_plus_4 (dec_pc_plus_4),
		.rd_sel (rd_sel),
		.update_rd (update_rd),
		.alu_opc (alu_opc),
		.alu_op1_ra (alu_op1_ra),
		.alu_op1_rb (alu_op1_rb),
		.alu_op2_rb (alu_op2_rb),
		.mem_load (mem_load),
		.mem_store (mem_store),
		.mem_width (mem_width),
		.branch_condition (branch_condition),
		.instr_class (instr_class),
		.is_call (is_call),
		.update_flags (update_flags),
		.cr_sel (cr_sel),
		.write_cr (write_cr),
		.branch_taken (branch_taken),
		.alu_out (alu_out),
		.mem_load_out (mem_load_out),
		.mem_store_out (mem_store_out),
		.mem_width_out (mem_width_out),
		.wr_val (wr_val),
		.wr_result (wr_result),
		.rd_sel_out (rd_sel_out),
		.stall_clear (stall_clear),
		.mar (mar),
		.mdr (mdr),
		.mem_wr_en (mem_wr_en),
		.is_swi (is_swi),
		.is_rfe (is_rfe),
		.vector_base (vector_base),
		.pc_plus_4_out (),
		.data_abort (data_abort)
	);

endmodule

//--- dv/oldland_exec_tb.sv
`timescale 1ns/1ps

module oldland_exec_tb
	import oldland_isa_pkg::*;
	import oldland_arch_pkg::*;
();

	localparam int data_width = 32;
	localparam int vector_align = 6;
	localparam int drain_timeout = 64;

	logic clk;
	logic rst;
	oldland_instr_t instr;
	logic instr_valid;
	logic [31:0] pc_plus_4;
	logic data_abort;
	logic [data_width-1:0] alu_out;
	logic branch_taken;
	logic stall_clear;
	logic wr_result;
	reg_idx_t rd_sel_out;
	logic [data_width-1:0] wr_val;
	logic [data_width-1:0] mar;
	logic [data_width-1:0] mdr;
	logic mem_wr_en;
	logic mem_load_out;
	logic mem_store_out;
	mem_width_t mem_width_out;
	logic [data_width-vector_align-1:0] vector_base;

	// expected events, consumed in program order by the monitors.
	reg_idx_t exp_wr_idx[$];
	logic [31:0] exp_wr_val[$];
	logic [31:0] exp_mar[$];
	logic [31:0] exp_mdr[$];
	logic exp_mem_wr[$];
	mem_width_t exp_width[$];
	logic exp_taken[$];

	logic [31:0] rng_state;
	int gap;

	oldland_exec_top #(
		.data_width (data_width),
		.vector_align (vector_align)
	) i_oldland_exec_top (
		.clk (clk),
		.rst (rst),
		.instr (instr),
		.instr_valid (instr_valid),
		.pc_plus_4 (pc_plus_4),
		.data_abort (data_abort),
		.alu_out (alu_out),
		.branch_taken (branch_taken),
		.stall_clear (stall_clear),
		.wr_result (wr_result),
		.rd_sel_out (rd_sel_out),
		.wr_val (wr_val),
		.mar (mar),
		.mdr (mdr),
		.mem_wr_en (mem_wr_en),
		.mem_load_out (mem_load_out),
		.mem_store_out (mem_store_out),
		.mem_width_out (mem_width_out),
		.vector_base (vector_base)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic end_with_failure(input string reason);
		$display("%s", reason);
		$display("Verification failed");
		$fatal(1, "run aborted");
	endtask

	task automatic check_word(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (actual !== expected) begin
			$display("ERROR: %s expected 0x%h actual 0x%h", name, expected, actual);
			end_with_failure("stopping at the first mismatch");
		end
	endtask

	task automatic check_reg(input string name, input reg_idx_t expected, input reg_idx_t actual);
		if (actual !== expected) begin
			$display("ERROR: %s expected 0x%h actual 0x%h", name, expected, actual);
			end_with_failure("stopping at the first mismatch");
		end
	endtask

	task automatic check_width(input string name, input mem_width_t expected,
			input mem_width_t actual);
		if (actual !== expected) begin
			$display("ERROR: %s expected 0x%h actual 0x%h", name, expected, actual);
			end_with_failure("stopping at the first mismatch");
		end
	endtask

	task automatic check_bit(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			$display("ERROR: %s expected 0x%h actual 0x%h", name, expected, actual);
			end_with_failure("stopping at the first mismatch");
		end
	endtask

	task automatic drive_bubbles(input int count);
		repeat (count) begin
			@(posedge clk);
			#2;
			instr_valid = 1'b0;
		end
	endtask

	function automatic bit queues_empty();
		return exp_wr_idx.size() == 0 && exp_mar.size() == 0 && exp_taken.size() == 0;
	endfunction

	// outputs settle right after the rising edge, so the monitors look at the falling edge.
	always @(negedge clk) begin
		if (rst === 1'b0) begin
			if (wr_result === 1'b1) begin
				if (exp_wr_idx.size() == 0)
					end_with_failure("register write-back seen with nothing expected");
				check_reg("rd_sel_out", exp_wr_idx.pop_front(), rd_sel_out);
				check_word("wr_val", exp_wr_val.pop_front(), wr_val);
			end
			if (mem_load_out === 1'b1 || mem_store_out === 1'b1) begin
				if (exp_mar.size() == 0)
					end_with_failure("memory request seen with nothing expected");
				check_word("mar", exp_mar[0], mar);
				// the address is computed by the ALU, so alu_out carries it too.
				check_word("alu_out", exp_mar[0], alu_out);
				void'(exp_mar.pop_front());
				check_bit("mem_wr_en", exp_mem_wr[0], mem_wr_en);
				check_bit("mem_store_out", exp_mem_wr[0], mem_store_out);
				check_bit("mem_load_out", !exp_mem_wr[0], mem_load_out);
				check_width("mem_width_out", exp_width.pop_front(), mem_width_out);
				if (exp_mem_wr[0])
					check_word("mdr", exp_mdr[0], mdr);
				void'(exp_mem_wr.pop_front());
				void'(exp_mdr.pop_front());
			end
			if (stall_clear === 1'b1) begin
				if (exp_taken.size() == 0)
					end_with_failure("branch seen with nothing expected");
				check_bit("branch_taken", exp_taken.pop_front(), branch_taken);
			end
		end
	end

	initial begin
		int fd;
		int n;
		int cycles;
		logic [7:0] kind;
		logic [8*200-1:0] line;
		logic [31:0] cls, op, rd, ra, rbc, sel, imm, pc;
		logic [31:0] v0, v1, v2, v3;
		oldland_instr_t word;

		rst = 1'b1;
		instr = '0;
		instr_valid = 1'b0;
		pc_plus_4 = '0;
		data_abort = 1'b0;
		rng_state = 32'd70;
		gap = 0;

		repeat (16) @(posedge clk);
		#2;
		rst = 1'b0;

		fd = $fopen("dv/exec_trace.txt", "r");
		if (fd == 0)
			end_with_failure("cannot open the trace file dv/exec_trace.txt");

		n = $fscanf(fd, " %c", kind);
		while (n == 1) begin
			case (kind)
			"#": n = $fgets(line, fd);
			"I": begin
				n = $fscanf(fd, "%h %h %h %h %h %h %h %h", cls, op, rd, ra, rbc, sel, imm, pc);
				if (n != 8)
					end_with_failure("malformed instruction line in the trace");
				word = '0;
				if (instr_class_t'(cls[1:0]) == class_alu) begin
					word.reg_fmt.iclass = class_alu;
					word.reg_fmt.opcode = op[4:0];
					word.reg_fmt.rd = rd[3:0];
					word.reg_fmt.ra = ra[3:0];
					word.reg_fmt.rb = rbc[3:0];
					word.reg_fmt.imm_sel = sel[0];
					word.reg_fmt.imm12 = imm[11:0];
				end else begin
					word.imm_fmt.iclass = instr_class_t'(cls[1:0]);
					word.imm_fmt.opcode = op[4:0];
					word.imm_fmt.rd = rd[3:0];
					word.imm_fmt.ra = ra[3:0];
					word.imm_fmt.cond = rbc[2:0];
					word.imm_fmt.imm14 = imm[13:0];
				end
				drive_bubbles(gap);
				@(posedge clk);
				#2;
				instr = word;
				instr_valid = 1'b1;
				pc_plus_4 = pc;
				// at least two empty slots keep a register write ahead of its next read.
				rng_state = xorshift32(rng_state);
				gap = 2 + rng_state % 2;
			end
			"E": begin
				n = $fscanf(fd, "%h %h", v0, v1);
				if (n != 2)
					end_with_failure("malformed write-back line in the trace");
				exp_wr_idx.push_back(reg_idx_t'(v0[3:0]));
				exp_wr_val.push_back(v1);
			end
			"M": begin
				n = $fscanf(fd, "%h %h %h %h", v0, v1, v2, v3);
				if (n != 4)
					end_with_failure("malformed memory line in the trace");
				exp_mar.push_back(v0);
				exp_mdr.push_back(v1);
				exp_mem_wr.push_back(v2[0]);
				exp_width.push_back(mem_width_t'(v3[1:0]));
			end
			"B": begin
				n = $fscanf(fd, "%h", v0);
				if (n != 1)
					end_with_failure("malformed branch line in the trace");
				exp_taken.push_back(v0[0]);
			end
			"V": begin
				n = $fscanf(fd, "%h", v0);
				if (n != 1)
					end_with_failure("malformed vector base line in the trace");
				drive_bubbles(gap);
				gap = 0;
				check_word("vector_base", v0, {vector_base, {vector_align{1'b0}}});
			end
			"A": begin
				drive_bubbles(gap);
				@(posedge clk);
				#2;
				instr_valid = 1'b0;
				data_abort = 1'b1;
				@(posedge clk);
				#2;
				data_abort = 1'b0;
				gap = 0;
			end
			default: end_with_failure("unknown line kind in the trace");
			endcase
			n = $fscanf(fd, " %c", kind);
		end
		$fclose(fd);

		drive_bubbles(gap);
		cycles = 0;
		while (!queues_empty() && cycles < drain_timeout) begin
			@(posedge clk);
			cycles++;
		end
		repeat (4) @(posedge clk);
		#1;
		if (!queues_empty()) begin
			end_with_failure("timed out with expected results never seen");
		end else begin
			$display("Verification passed");
			$finish;
		end
	end

endmodule

//--- dv/exec_trace.txt
# I cls op rd ra rb_or_cond imm_sel imm pc_plus_4 | E rd value | M mar mdr store width
# B taken | V vector_base | A data abort pulse; every field is hex
I 0 0b 1 0 0 1 005 00000104
E 1 00000005
I 0 0b 2 0 0 1 7ff 00000108
E 2 000007ff
I 0 0b 3 0 0 1 ffe 0000010c
E 3 fffffffe
I 0 00 4 1 2 0 000 00000110
E 4 00000804
I 0 02 5 1 3 0 000 00000114
E 5 00000007
I 0 07 6 4 2 0 000 00000118
E 6 00000ffb
I 0 04 7 1 0 1 004 0000011c
E 7 00000050
I 0 0e 8 3 0 1 001 00000120
E 8 ffffffff
I 0 09 9 1 0 1 008 00000124
E 9 00000105
I 0 08 a 9 0 1 000 00000128
E a 00000104
I 0 06 b 4 2 0 000 0000012c
E b 00000004
# flags and conditional branches
I 0 0c 0 1 1 0 000 00000130
I 1 00 0 0 2 0 0010 00000134
B 1
I 1 00 0 0 1 0 0010 00000138
B 0
I 0 0c 0 1 5 0 000 0000013c
I 1 00 0 0 6 0 0010 00000140
B 1
I 1 00 0 0 5 0 0010 00000144
B 0
I 0 0c 0 5 1 0 000 00000148
I 1 00 0 0 5 0 0010 0000014c
B 1
I 1 00 0 0 6 0 0010 00000150
B 0
# stores, a load and a data abort
I 2 06 5 1 0 0 0010 00000154
M 00000015 00000007 1 2
I 2 04 6 4 0 0 3ffc 00000158
M 00000800 00000ffb 1 0
I 2 01 0 4 0 0 0020 0000015c
M 00000824 00000000 0 1
A
I 3 00 c 0 4 0 0000 00000160
E c 00000824
I 1 01 e 0 7 0 0040 00000200
E e 00000200
B 1
# control registers, swi and rfe
I 0 0b d 0 0 1 7c0 00000204
E d 000007c0
I 3 01 0 d 0 0 0000 00000208
V 000007c0
I 3 00 f 0 0 0 0000 0000020c
E f 000007c0
I 0 0c 0 1 5 0 000 00000210
I 3 00 7 0 1 0 0000 00000214
E 7 0000000a
I 1 02 0 0 0 0 0000 00000218
B 1
I 0 0c 0 1 1 0 000 0000021c
I 3 00 7 0 1 0 0000 00000220
E 7 00000001
I 3 00 8 0 2 0 0000 00000224
E 8 0000000a
I 1 03 0 0 0 0 0000 00000228
B 1
I 3 00 7 0 1 0 0000 0000022c
E 7 0000000a

//--- src.f
design/oldland_isa_pkg.sv
design/oldland_arch_pkg.sv
design/oldland_regfile.sv
design/oldland_decode.sv
design/oldland_exec.sv
design/oldland_exec_top.sv
dv/oldland_exec_tb.sv

//--- Bender.yml
package:
  name: oldland_exec

sources:
  - design/oldland_isa_pkg.sv
  - design/oldland_arch_pkg.sv
  - design/oldland_regfile.sv
  - design/oldland_decode.sv
  - design/oldland_exec.sv
  - design/oldland_exec_top.sv
  - target: test
    files:
      - dv/oldland_exec_tb.sv
